// File: design/demux_cfg_pkg.sv
// --------------------
// sizes, region map and FSM state encoding for the transaction demux
// region table is fixed at compile time, four regions of 256 MiB each
// addresses outside every region are unmapped and get a decode error
// --------------------
package demux_cfg_pkg;

  // --------------------
  // sizes
  // --------------------
  localparam int unsigned NUM_PORTS   = 4;
  localparam int unsigned ID_BITS     = 2;
  localparam int unsigned NUM_IDS     = 2 ** ID_BITS;
  localparam int unsigned CNT_WIDTH   = 4;
  localparam int unsigned ADDR_WIDTH  = 32;
  // stall cycles tolerated before the sticky timeout
  localparam int unsigned STALL_LIMIT = 64;
  // wide enough to hold STALL_LIMIT itself
  localparam int unsigned STALL_CNT_W = $clog2(STALL_LIMIT + 1);

  typedef logic [$clog2(NUM_PORTS)-1:0] port_sel_t;
  typedef logic [ID_BITS-1:0]           axi_id_t;
  typedef logic [CNT_WIDTH-1:0]         cnt_t;
  typedef logic [STALL_CNT_W-1:0]       stall_cnt_t;

  // --------------------
  // region table, entry i maps to port i
  // --------------------
  localparam logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0] REGION_BASE = {
    32'h4000_0000,
    32'h2000_0000,
    32'h1000_0000,
    32'h0000_0000
  };
  // same mask everywhere, top nibble selects the region
  localparam logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0] REGION_MASK = {
    32'hF000_0000,
    32'hF000_0000,
    32'hF000_0000,
    32'hF000_0000
  };

  // request FSM
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_CHECK = 2'd1,
    ST_STALL = 2'd2
  } fsm_state_e;

endpackage

// File: design/demux_bus_pkg.sv
// --------------------
// request, issue and response bundles of the demux
// req_t is 36 bits: id, addr, op from msb to lsb
// every valid bit here is a single-cycle strobe except the request level
// --------------------
package demux_bus_pkg;

  // --------------------
  // opcodes
  // --------------------
  // an atomic occupies both a write and a read response slot
  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_ATOP  = 2'd2
  } opcode_e;

  // --------------------
  // bundles
  // --------------------
  // request from the slave side, held until accepted
  typedef struct packed {
    demux_cfg_pkg::axi_id_t               id;
    logic [demux_cfg_pkg::ADDR_WIDTH-1:0] addr;
    opcode_e                              op;
  } req_t;

  // issue strobe towards the selected master port
  typedef struct packed {
    logic                     valid;
    demux_cfg_pkg::port_sel_t port;
    demux_cfg_pkg::axi_id_t   id;
    opcode_e                  op;
  } issue_t;

  // one completed response for id
  typedef struct packed {
    logic                   valid;
    demux_cfg_pkg::axi_id_t id;
  } rsp_t;

endpackage

// File: design/in_flight_counter.sv
// --------------------
// up/down counter stepping by delta_i when enabled
// overflow_o flags a step that wraps past zero or past the maximum,
// the stored value still wraps, so the caller must not rely on it then
// --------------------
`timescale 1ns/1ps

module in_flight_counter (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                en_i,
  input  logic                down_i,
  input  demux_cfg_pkg::cnt_t delta_i,
  output demux_cfg_pkg::cnt_t q_o,
  output logic                overflow_o
);
  import demux_cfg_pkg::*;

  cnt_t               cnt_q;
  // one extra bit catches carry on add and borrow on subtract
  logic [CNT_WIDTH:0] step_ext;

  // --------------------
  // next value
  // --------------------
  always_comb begin
    if (down_i) begin
      step_ext = {1'b0, cnt_q} - {1'b0, delta_i};
    end else begin
      step_ext = {1'b0, cnt_q} + {1'b0, delta_i};
    end
  end

  // only a real step can wrap
  assign overflow_o = en_i & step_ext[CNT_WIDTH];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (en_i) begin
      cnt_q <= step_ext[CNT_WIDTH-1:0];
    end
  end

  assign q_o = cnt_q;

endmodule

// File: design/addr_port_decoder.sv
// --------------------
// masked compare against the region table, lowest entry wins
// no match gives unmapped_o with port_o zero
// --------------------
`timescale 1ns/1ps

module addr_port_decoder (
  input  logic [demux_cfg_pkg::ADDR_WIDTH-1:0] addr_i,
  output demux_cfg_pkg::port_sel_t             port_o,
  output logic                                 unmapped_o
);
  import demux_cfg_pkg::*;

  logic [NUM_PORTS-1:0] hit;

  // one comparator per region
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_region
    assign hit[i] = ((addr_i & REGION_MASK[i]) == REGION_BASE[i]);
  end

  // --------------------
  // priority pick
  // --------------------
  always_comb begin
    port_o     = '0;
    unmapped_o = 1'b1;
    // walk downwards so the lowest matching entry is written last
    for (int i = NUM_PORTS - 1; i >= 0; i--) begin
      if (hit[i]) begin
        port_o     = port_sel_t'(i);
        unmapped_o = 1'b0;
      end
    end
  end

endmodule

// File: design/demux_id_counters.sv
// --------------------
// one in-flight counter and one port register per ID
// inject always refers to the push ID, it is only used for atomics
// full_o is saturation on any ID or a wrap seen in the previous cycle,
// an atomic pushed at max-1 still wraps that counter
// --------------------
`timescale 1ns/1ps

module demux_id_counters (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // lookup of the captured request ID
  input  demux_cfg_pkg::axi_id_t   lookup_id_i,
  output demux_cfg_pkg::port_sel_t lookup_port_o,
  output logic                     lookup_occupied_o,
  // push on issue, inject adds the extra atomic slot
  input  logic                     push_i,
  input  demux_cfg_pkg::axi_id_t   push_id_i,
  input  demux_cfg_pkg::port_sel_t push_port_i,
  input  logic                     inject_i,
  // pop on response
  input  logic                     pop_i,
  input  demux_cfg_pkg::axi_id_t   pop_id_i,
  output logic                     full_o
);
  import demux_cfg_pkg::*;

  port_sel_t [NUM_IDS-1:0] port_q;
  cnt_t      [NUM_IDS-1:0] in_flight;
  logic      [NUM_IDS-1:0] push_en;
  logic      [NUM_IDS-1:0] inject_en;
  logic      [NUM_IDS-1:0] pop_en;
  logic      [NUM_IDS-1:0] occupied;
  logic      [NUM_IDS-1:0] wrap;
  logic      [NUM_IDS-1:0] wrap_q;
  logic      [NUM_IDS-1:0] cnt_full;

  // --------------------
  // lookup
  // --------------------
  assign lookup_port_o     = port_q[lookup_id_i];
  assign lookup_occupied_o = occupied[lookup_id_i];
  assign full_o            = |cnt_full;

  for (genvar i = 0; i < NUM_IDS; i++) begin : gen_id
    logic cnt_en;
    logic cnt_down;
    cnt_t cnt_delta;

    // strobes for this ID only
    assign push_en[i]   = push_i & (push_id_i == axi_id_t'(i));
    assign inject_en[i] = inject_i & push_en[i];
    assign pop_en[i]    = pop_i & (pop_id_i == axi_id_t'(i));

    // net step of push, inject and pop in the same cycle
    always_comb begin
      cnt_en    = 1'b1;
      cnt_down  = 1'b0;
      cnt_delta = cnt_t'(1);
      case ({push_en[i], inject_en[i], pop_en[i]})
        // response only
        3'b001: cnt_down = 1'b1;
        // plain push, or atomic push with a pop
        3'b100, 3'b111: cnt_delta = cnt_t'(1);
        // atomic push counts two responses
        3'b110: cnt_delta = cnt_t'(2);
        // idle, or push and pop cancel out
        default: begin
          cnt_en    = 1'b0;
          cnt_delta = cnt_t'(0);
        end
      endcase
    end

    in_flight_counter in_flight_counter_inst (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .en_i       (cnt_en),
      .down_i     (cnt_down),
      .delta_i    (cnt_delta),
      .q_o        (in_flight[i]),
      .overflow_o (wrap[i])
    );

    assign occupied[i] = |in_flight[i];
    // registered wrap keeps full_o off the push path
    assign cnt_full[i] = (&in_flight[i]) | wrap_q[i];

    // port of the latest push for this ID
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        port_q[i] <= '0;
      end else if (push_en[i]) begin
        port_q[i] <= push_port_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wrap_q <= '0;
    end else begin
      wrap_q <= wrap;
    end
  end

endmodule

// File: design/stall_timer.sv
// --------------------
// counts consecutive stall cycles, restarts when stall drops
// the error stays set until reset
// --------------------
`timescale 1ns/1ps

module stall_timer (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic stall_i,
  output logic stall_err_o
);
  import demux_cfg_pkg::*;

  stall_cnt_t cnt_q;
  logic       at_limit;
  logic       err_q;

  assign at_limit = (cnt_q == stall_cnt_t'(STALL_LIMIT));

  // saturate at the limit so the count never wraps
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (!stall_i) begin
      cnt_q <= '0;
    end else if (!at_limit) begin
      cnt_q <= cnt_q + stall_cnt_t'(1);
    end
  end

  // sticky
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else if (at_limit) begin
      err_q <= 1'b1;
    end
  end

  assign stall_err_o = err_q;

endmodule

// File: design/issue_fsm.sv
// --------------------
// captures one request at a time and issues it when ordering allows
// the request level must stay high until accept_o
// decision outputs are combinational in ST_CHECK and ST_STALL
// at most one accept every two cycles
// --------------------
`timescale 1ns/1ps

module issue_fsm (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     req_valid_i,
  input  demux_bus_pkg::req_t      req_i,
  // decode of req_q
  input  demux_cfg_pkg::port_sel_t dec_port_i,
  input  logic                     dec_unmapped_i,
  // counter state of req_q.id
  input  logic                     occupied_i,
  input  demux_cfg_pkg::port_sel_t occ_port_i,
  input  logic                     full_i,
  output demux_bus_pkg::req_t      req_q_o,
  output logic                     accept_o,
  output demux_bus_pkg::issue_t    issue_o,
  output logic                     decerr_o,
  output logic                     push_o,
  output logic                     inject_o,
  output logic                     stall_o
);
  import demux_cfg_pkg::*;
  import demux_bus_pkg::*;

  fsm_state_e state_q;
  fsm_state_e state_d;
  req_t       req_q;
  logic       deciding;
  logic       conflict;
  logic       go;

  // --------------------
  // issue rule
  // --------------------
  always_comb begin
    deciding = (state_q == ST_CHECK) || (state_q == ST_STALL);
    // same ID busy on another port would break ordering
    conflict = (occupied_i && (occ_port_i != dec_port_i)) || full_i;
    go       = deciding && !dec_unmapped_i && !conflict;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (req_valid_i) begin
          state_d = ST_CHECK;
        end
      end
      ST_CHECK, ST_STALL: begin
        // decode errors never wait for the counters
        if (dec_unmapped_i || !conflict) begin
          state_d = ST_IDLE;
        end else begin
          state_d = ST_STALL;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // request payload, loaded only when sampled in idle
  always_ff @(posedge clk_i) begin
    if ((state_q == ST_IDLE) && req_valid_i) begin
      req_q <= req_i;
    end
  end

  // --------------------
  // outputs
  // --------------------
  assign accept_o = deciding && (dec_unmapped_i || !conflict);
  assign decerr_o = deciding && dec_unmapped_i;
  assign push_o   = go;
  // second outstanding slot for the atomic's read response
  assign inject_o = go && (req_q.op == OP_ATOP);
  assign stall_o  = (state_q == ST_STALL);
  assign req_q_o  = req_q;

  always_comb begin
    issue_o.valid = go;
    issue_o.port  = dec_port_i;
    issue_o.id    = req_q.id;
    issue_o.op    = req_q.op;
  end

endmodule

// File: design/txn_demux_top.sv
// --------------------
// ID-ordered request demux over four master ports
// responses are pop strobes only, their routing is not modelled
// one request in the FSM at a time, many outstanding downstream
// --------------------
`timescale 1ns/1ps

module txn_demux_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_valid_i,
  input  demux_bus_pkg::req_t   req_i,
  output logic                  accept_o,
  output demux_bus_pkg::issue_t issue_o,
  output logic                  decerr_o,
  input  demux_bus_pkg::rsp_t   rsp_i,
  output logic                  stall_err_o
);
  import demux_cfg_pkg::*;
  import demux_bus_pkg::*;

  req_t      req_q;
  port_sel_t dec_port;
  logic      dec_unmapped;
  port_sel_t occ_port;
  logic      occupied;
  logic      full;
  logic      push;
  logic      inject;
  logic      stall;

  // --------------------
  // request path
  // --------------------
  issue_fsm issue_fsm_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .dec_port_i     (dec_port),
    .dec_unmapped_i (dec_unmapped),
    .occupied_i     (occupied),
    .occ_port_i     (occ_port),
    .full_i         (full),
    .req_q_o        (req_q),
    .accept_o       (accept_o),
    .issue_o        (issue_o),
    .decerr_o       (decerr_o),
    .push_o         (push),
    .inject_o       (inject),
    .stall_o        (stall)
  );

  // decodes the captured address, not the live input
  addr_port_decoder addr_port_decoder_inst (
    .addr_i     (req_q.addr),
    .port_o     (dec_port),
    .unmapped_o (dec_unmapped)
  );

  // --------------------
  // ordering state
  // --------------------
  demux_id_counters demux_id_counters_inst (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .lookup_id_i       (req_q.id),
    .lookup_port_o     (occ_port),
    .lookup_occupied_o (occupied),
    .push_i            (push),
    .push_id_i         (req_q.id),
    .push_port_i       (dec_port),
    .inject_i          (inject),
    .pop_i             (rsp_i.valid),
    .pop_id_i          (rsp_i.id),
    .full_o            (full)
  );

  stall_timer stall_timer_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .stall_i     (stall),
    .stall_err_o (stall_err_o)
  );

endmodule

// File: tb/txn_demux_assert.sv
// --------------------
// concurrent checks bound into the FSM and the ID counters
// unused inputs of each bind are tied to idle values
// --------------------
`timescale 1ns/1ps

module txn_demux_assert (
  input logic                                              clk_i,
  input logic                                              rst_n_i,
  input demux_cfg_pkg::fsm_state_e                         state_i,
  input logic                                              accept_i,
  input logic                                              push_i,
  input logic                                              full_i,
  input logic                                              pop_i,
  input demux_cfg_pkg::axi_id_t                            pop_id_i,
  input demux_cfg_pkg::cnt_t [demux_cfg_pkg::NUM_IDS-1:0]  in_flight_i
);
  import demux_cfg_pkg::*;

  // failed assertions in this instance
  int fail_cnt = 0;

  // one accept per request, the decision state hands back to idle
  accept_back_to_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accept_i |=> (state_i == ST_IDLE))
    else begin
      fail_cnt++;
      $error("FSM not back in ST_IDLE after accept");
    end

  // a response must have something to retire
  pop_not_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> (in_flight_i[pop_id_i] != '0))
    else begin
      fail_cnt++;
      $error("response popped an ID with a zero count");
    end

  // the FSM must hold back issues while a counter is saturated
  push_not_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_i)
    else begin
      fail_cnt++;
      $error("push reached the counters while full");
    end

endmodule

bind issue_fsm txn_demux_assert fsm_assert_inst (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .state_i     (state_q),
  .accept_i    (accept_o),
  .push_i      (1'b0),
  .full_i      (1'b0),
  .pop_i       (1'b0),
  .pop_id_i    ('0),
  .in_flight_i ('0)
);

bind demux_id_counters txn_demux_assert cnt_assert_inst (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .state_i     (demux_cfg_pkg::ST_IDLE),
  .accept_i    (1'b0),
  .push_i      (push_i),
  .full_i      (full_o),
  .pop_i       (pop_i),
  .pop_id_i    (pop_id_i),
  .in_flight_i (in_flight)
);

// File: tb/txn_demux_tb.sv
// --------------------
// directed testbench for the transaction demux
// requests are held until accept, responses are single pops
// a small model keeps the expected count and port per ID
// the first mismatch ends the run, a watchdog bounds it
// --------------------
`timescale 1ns/1ps

module txn_demux_tb;
  import demux_cfg_pkg::*;
  import demux_bus_pkg::*;

  // total budget, 200 cycles per test plus room for the timeout case
  localparam int WATCHDOG_CYCLES = 6 * 200 + 2 * STALL_LIMIT;

  logic   clk_i;
  logic   rst_n_i;
  logic   req_valid_i;
  req_t   req_i;
  logic   accept_o;
  issue_t issue_o;
  logic   decerr_o;
  rsp_t   rsp_i;
  logic   stall_err_o;

  // last request result, read back after send_req
  issue_t got_issue;
  logic   got_decerr;
  int     got_lat;

  int          exp_cnt  [NUM_IDS];
  int          exp_port [NUM_IDS];
  int          seed = 32'h2e8;
  logic [3:0]  region_nib [NUM_PORTS] = '{4'h0, 4'h1, 4'h2, 4'h4};

  txn_demux_top txn_demux_top_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .accept_o    (accept_o),
    .issue_o     (issue_o),
    .decerr_o    (decerr_o),
    .rsp_i       (rsp_i),
    .stall_err_o (stall_err_o)
  );

  always #5 clk_i = ~clk_i;

  // --------------------
  // helpers
  // --------------------
  task automatic abort_run(input string why);
    $display("TEST FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_eq(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
      abort_run("value mismatch");
    end
  endtask

  // failures counted by both bound checker instances
  function automatic int assert_failures();
    return txn_demux_top_inst.issue_fsm_inst.fsm_assert_inst.fail_cnt
         + txn_demux_top_inst.demux_id_counters_inst.cnt_assert_inst.fail_cnt;
  endfunction

  // port from the top nibble, -1 for unmapped
  function automatic int region_of(input logic [31:0] addr);
    case (addr[31:28])
      4'h0:    return 0;
      4'h1:    return 1;
      4'h2:    return 2;
      4'h4:    return 3;
      default: return -1;
    endcase
  endfunction

  // random offset inside the region of nibble nib
  function automatic logic [31:0] addr_in(input logic [3:0] nib);
    logic [31:0] rnd;
    rnd = $random(seed);
    return {nib, rnd[27:0]};
  endfunction

  // hold the level until accept, latency counts from the sampling edge
  task automatic send_req(input axi_id_t id, input logic [31:0] addr, input opcode_e op);
    req_t r;
    r.id   = id;
    r.addr = addr;
    r.op   = op;
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_i       <= r;
    got_lat = 0;
    @(negedge clk_i);
    while (!accept_o) begin
      @(negedge clk_i);
      got_lat++;
    end
    got_issue  = issue_o;
    got_decerr = decerr_o;
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  task automatic send_rsp(input axi_id_t id);
    rsp_t r;
    r.valid = 1'b1;
    r.id    = id;
    if (exp_cnt[id] == 0) begin
      abort_run("response pop for an ID with nothing outstanding");
    end
    @(posedge clk_i);
    rsp_i <= r;
    @(posedge clk_i);
    rsp_i <= '0;
    exp_cnt[id]--;
  endtask

  // send one request, check the result against the model and update it
  task automatic request_and_check(input string name, input axi_id_t id,
                                   input logic [31:0] addr, input opcode_e op);
    int port;
    bit blocked;
    port    = region_of(addr);
    // busy on another port, or any count at its maximum, holds a mapped request
    blocked = (port >= 0) && (exp_cnt[id] > 0) && (exp_port[id] != port);
    for (int i = 0; i < NUM_IDS; i++) begin
      if ((port >= 0) && (exp_cnt[i] == (1 << CNT_WIDTH) - 1)) begin
        blocked = 1'b1;
      end
    end
    send_req(id, addr, op);
    if (blocked) begin
      check_eq({name, " stalled"}, 1, int'(got_lat > 1));
    end else begin
      check_eq({name, " latency"}, 1, got_lat);
    end
    if (port < 0) begin
      check_eq({name, " decerr"}, 1, int'(got_decerr));
      check_eq({name, " issue valid"}, 0, int'(got_issue.valid));
    end else begin
      check_eq({name, " decerr"}, 0, int'(got_decerr));
      check_eq({name, " issue valid"}, 1, int'(got_issue.valid));
      check_eq({name, " port"}, port, int'(got_issue.port));
      check_eq({name, " id"}, int'(id), int'(got_issue.id));
      check_eq({name, " op"}, int'(op), int'(got_issue.op));
      // an atomic waits for both a write and a read response
      exp_cnt[id]  += (op == OP_ATOP) ? 2 : 1;
      exp_port[id]  = port;
    end
  endtask

  task automatic expect_no_accept(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check_eq("stalled accept", 0, int'(accept_o));
    end
  endtask

  task automatic drain_outstanding();
    for (int i = 0; i < NUM_IDS; i++) begin
      while (exp_cnt[i] > 0) begin
        send_rsp(axi_id_t'(i));
      end
    end
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic reset_and_routing();
    @(negedge clk_i);
    check_eq("reset accept", 0, int'(accept_o));
    check_eq("reset issue", 0, int'(issue_o.valid));
    check_eq("reset decerr", 0, int'(decerr_o));
    check_eq("reset stall_err", 0, int'(stall_err_o));
    for (int p = 0; p < NUM_PORTS; p++) begin
      request_and_check("routing", axi_id_t'(p), addr_in(region_nib[p]),
                        opcode_e'(2'(p % 3)));
    end
    drain_outstanding();
  endtask

  task automatic decode_error();
    request_and_check("decode error", 2'd2, addr_in(4'h8), OP_READ);
    request_and_check("after decerr", 2'd2, addr_in(4'h2), OP_WRITE);
    drain_outstanding();
  endtask

  task automatic same_port_ordering();
    request_and_check("same port", 2'd0, addr_in(4'h1), OP_READ);
    request_and_check("same port", 2'd0, addr_in(4'h1), OP_WRITE);
    request_and_check("same port", 2'd0, addr_in(4'h1), OP_ATOP);
    request_and_check("same port", 2'd0, addr_in(4'h1), OP_READ);
    drain_outstanding();
  endtask

  task automatic port_conflict();
    request_and_check("conflict setup", 2'd1, addr_in(4'h0), OP_READ);
    request_and_check("conflict setup", 2'd1, addr_in(4'h0), OP_WRITE);
    // another ID is not held back by ID 1
    request_and_check("other id", 2'd2, addr_in(4'h4), OP_READ);
    fork
      request_and_check("port conflict", 2'd1, addr_in(4'h2), OP_WRITE);
      begin
        expect_no_accept(6);
        send_rsp(2'd1);
        expect_no_accept(3);
        send_rsp(2'd1);
      end
    join
    drain_outstanding();
  endtask

  task automatic atomics_and_saturation();
    request_and_check("atomic", 2'd0, addr_in(4'h0), OP_ATOP);
    fork
      request_and_check("atomic conflict", 2'd0, addr_in(4'h1), OP_READ);
      begin
        expect_no_accept(4);
        send_rsp(2'd0);
        // one slot is still held by the atomic
        expect_no_accept(4);
        send_rsp(2'd0);
      end
    join
    drain_outstanding();
    // fill ID 3 up to the counter maximum
    repeat ((1 << CNT_WIDTH) - 1) begin
      request_and_check("fill", 2'd3, addr_in(4'h1), OP_READ);
    end
    fork
      request_and_check("saturated", 2'd3, addr_in(4'h1), OP_READ);
      begin
        expect_no_accept(5);
        send_rsp(2'd3);
      end
    join
    drain_outstanding();
  endtask

  task automatic stall_timeout();
    check_eq("stall_err before", 0, int'(stall_err_o));
    request_and_check("timeout setup", 2'd1, addr_in(4'h0), OP_READ);
    fork
      request_and_check("stall timeout", 2'd1, addr_in(4'h4), OP_WRITE);
      begin
        expect_no_accept(STALL_LIMIT + 8);
        check_eq("stall_err raised", 1, int'(stall_err_o));
        send_rsp(2'd1);
      end
    join
    @(negedge clk_i);
    // sticky after the conflict cleared
    check_eq("stall_err sticky", 1, int'(stall_err_o));
    drain_outstanding();
  endtask

  // --------------------
  // main sequence and watchdog
  // --------------------
  initial begin
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_i       = '0;
    for (int i = 0; i < NUM_IDS; i++) begin
      exp_cnt[i]  = 0;
      exp_port[i] = 0;
    end
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    reset_and_routing();
    decode_error();
    same_port_ordering();
    port_conflict();
    atomics_and_saturation();
    stall_timeout();
    if (assert_failures() != 0) begin
      abort_run("a concurrent assertion on the FSM or the counters failed");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    abort_run("watchdog timeout, the DUT never accepted a pending request");
  end

endmodule

// File: txn_demux.f
design/demux_cfg_pkg.sv
design/demux_bus_pkg.sv
design/in_flight_counter.sv
design/addr_port_decoder.sv
design/demux_id_counters.sv
design/stall_timer.sv
design/issue_fsm.sv
design/txn_demux_top.sv
tb/txn_demux_assert.sv
tb/txn_demux_tb.sv

// File: Makefile
TOP := txn_demux_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f txn_demux.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
